// ==== hdl/corePkg.sv ====
package corePkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;

    typedef logic [DataWidth-1:0]    word_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;

    localparam word_t DefaultResetPc = 32'hBFC0_0000; // boot rom vector

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpBeq     = 6'h04;
    localparam logic [5:0] OpBne     = 6'h05;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpOri     = 6'h0D;
    localparam logic [5:0] OpLui     = 6'h0F;

    // SPECIAL funct field, instr[5:0]
    localparam logic [5:0] FunctSll  = 6'h00;
    localparam logic [5:0] FunctAddu = 6'h21;
    localparam logic [5:0] FunctSubu = 6'h23;
    localparam logic [5:0] FunctAnd  = 6'h24;
    localparam logic [5:0] FunctOr   = 6'h25;
    localparam logic [5:0] FunctXor  = 6'h26;
    localparam logic [5:0] FunctSlt  = 6'h2A;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSll, AluLui
    } aluOp_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        aluOp_t   aluOp;
        word_t    operandA;   // forwarded rs
        word_t    operandB;   // forwarded rt or extended imm
        logic [4:0] shamt;
        logic     regWrite;
        regAddr_t writeReg;
    } decToExe_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     regWrite;
        regAddr_t writeReg;
        word_t    result;
    } exeToWb_t;

endpackage

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/1ns

module fetchUnit #(
    parameter corePkg::word_t ResetPc = corePkg::DefaultResetPc
) (
    input  logic           clk,
    input  logic           rstN_i,
    input  logic           redirect_i,
    input  corePkg::word_t redirectPc_i,
    input  corePkg::word_t instData_i,
    output corePkg::word_t instAddr_o,
    output logic           instEn_o,
    output logic           fetchValid_o,
    output corePkg::word_t fetchPc_o,
    output corePkg::word_t fetchInstr_o
);

    corePkg::word_t pc;
    corePkg::word_t nextPc;
    corePkg::word_t f2Pc;       // address of the word now returning
    logic           f2Valid;
    logic           f2Squash;   // request left on the wrong path

    // nothing stalls the front end, one request every cycle
    assign instEn_o   = 1'b1;
    assign instAddr_o = pc;

    // branch target wins over the sequential address
    assign nextPc = redirect_i ? redirectPc_i : pc + 32'd4;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pc <= ResetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // F2 tags travel with the request
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            f2Valid  <= 1'b0;
            f2Squash <= 1'b0;
        end else begin
            f2Valid  <= instEn_o;
            f2Squash <= redirect_i; // fetched in the redirect cycle, i.e. branch pc + 8
        end
    end

    always_ff @(posedge clk) begin
        f2Pc <= pc;
    end

    assign fetchValid_o = f2Valid & ~f2Squash;
    assign fetchPc_o    = f2Pc;
    assign fetchInstr_o = instData_i; // memory answers one edge after the address

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic              clk,
    input  logic              rstN_i,
    input  corePkg::regAddr_t rdAddrA_i,
    input  corePkg::regAddr_t rdAddrB_i,
    input  logic              wrEn_i,
    input  corePkg::regAddr_t wrAddr_i,
    input  corePkg::word_t    wrData_i,
    output corePkg::word_t    rdDataA_o,
    output corePkg::word_t    rdDataB_o
);

    corePkg::word_t regs [1:31]; // $0 has no storage

    // read with write-through so writeback needs no separate bypass
    function automatic corePkg::word_t readPort(input corePkg::regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn_i && wrAddr_i == addr) begin
            return wrData_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && wrAddr_i != '0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    always_comb begin
        rdDataA_o = readPort(rdAddrA_i);
        rdDataB_o = readPort(rdAddrB_i);
    end

endmodule

// ==== hdl/decodeUnit.sv ====
`timescale 1ns/1ns

module decodeUnit (
    input  logic               clk,
    input  logic               rstN_i,
    input  logic               fetchValid_i,
    input  corePkg::word_t     fetchPc_i,
    input  corePkg::word_t     fetchInstr_i,
    input  corePkg::word_t     exeResult_i,
    input  logic               exeRegWrite_i,
    input  corePkg::regAddr_t  exeWriteReg_i,
    output logic               redirect_o,
    output corePkg::word_t     redirectPc_o,
    output corePkg::decToExe_t exeStage_o,
    output corePkg::regAddr_t  rfAddrA_o,
    output corePkg::regAddr_t  rfAddrB_o,
    input  corePkg::word_t     rfDataA_i,
    input  corePkg::word_t     rfDataB_i
);

    logic               dValid;
    corePkg::word_t     dPc;
    corePkg::word_t     dInstr;

    logic [5:0]         opcode;
    logic [5:0]         funct;
    corePkg::regAddr_t  rs;
    corePkg::regAddr_t  rt;
    corePkg::regAddr_t  rd;
    logic [4:0]         shamt;
    logic [15:0]        imm;

    corePkg::aluOp_t    aluOp;
    logic               known;      // opcode/funct is one we execute
    logic               useImm;
    logic               signExt;
    logic               destRt;
    logic               regWriteDec;
    logic               isBeq;
    logic               isBne;

    corePkg::word_t     immExt;
    corePkg::regAddr_t  writeReg;
    corePkg::word_t     rsVal;
    corePkg::word_t     rtVal;
    corePkg::decToExe_t exeD;

    // decode input register
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            dValid <= 1'b0;
        end else begin
            dValid <= fetchValid_i;
        end
    end

    always_ff @(posedge clk) begin
        dPc    <= fetchPc_i;
        dInstr <= fetchInstr_i;
    end

    assign opcode = dInstr[31:26];
    assign rs     = dInstr[25:21];
    assign rt     = dInstr[20:16];
    assign rd     = dInstr[15:11];
    assign shamt  = dInstr[10:6];
    assign funct  = dInstr[5:0];
    assign imm    = dInstr[15:0];

    always_comb begin
        aluOp       = corePkg::AluAdd;
        known       = 1'b1;
        useImm      = 1'b0;
        signExt     = 1'b1;     // branches need the signed offset
        destRt      = 1'b0;
        regWriteDec = 1'b0;
        isBeq       = 1'b0;
        isBne       = 1'b0;
        case (opcode)
            corePkg::OpSpecial: begin
                regWriteDec = 1'b1;
                case (funct)
                    corePkg::FunctAddu: aluOp = corePkg::AluAdd;
                    corePkg::FunctSubu: aluOp = corePkg::AluSub;
                    corePkg::FunctAnd:  aluOp = corePkg::AluAnd;
                    corePkg::FunctOr:   aluOp = corePkg::AluOr;
                    corePkg::FunctXor:  aluOp = corePkg::AluXor;
                    corePkg::FunctSlt:  aluOp = corePkg::AluSlt;
                    corePkg::FunctSll:  aluOp = corePkg::AluSll;
                    default: begin
                        known       = 1'b0;
                        regWriteDec = 1'b0;
                    end
                endcase
            end
            corePkg::OpAddiu: begin
                useImm      = 1'b1;
                destRt      = 1'b1;
                regWriteDec = 1'b1;
            end
            corePkg::OpOri: begin
                aluOp       = corePkg::AluOr;
                useImm      = 1'b1;
                signExt     = 1'b0;
                destRt      = 1'b1;
                regWriteDec = 1'b1;
            end
            corePkg::OpLui: begin
                aluOp       = corePkg::AluLui;
                useImm      = 1'b1;
                signExt     = 1'b0;
                destRt      = 1'b1;
                regWriteDec = 1'b1;
            end
            corePkg::OpBeq: isBeq = 1'b1;
            corePkg::OpBne: isBne = 1'b1;
            default:        known = 1'b0; // turns into a bubble
        endcase
    end

    assign immExt   = signExt ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    assign writeReg = destRt ? rt : rd;

    assign rfAddrA_o = rs;
    assign rfAddrB_o = rt;

    // execute result first, the file covers writeback by write-through
    function automatic corePkg::word_t forwardOperand(
        input corePkg::regAddr_t src,
        input corePkg::word_t    rfData
    );
        if (src != '0 && exeRegWrite_i && exeWriteReg_i == src) begin
            return exeResult_i;
        end
        return rfData;
    endfunction

    always_comb begin
        rsVal = forwardOperand(rs, rfDataA_i);
        rtVal = forwardOperand(rt, rfDataB_i);
    end

    // branches resolve here, one delay slot follows
    assign redirect_o   = dValid & ((isBeq & (rsVal == rtVal)) | (isBne & (rsVal != rtVal)));
    assign redirectPc_o = dPc + 32'd4 + {immExt[29:0], 2'b00};

    always_comb begin
        exeD.valid    = dValid & known;
        exeD.pc       = dPc;
        exeD.aluOp    = aluOp;
        exeD.operandA = rsVal;
        exeD.operandB = useImm ? immExt : rtVal;
        exeD.shamt    = shamt;
        exeD.regWrite = dValid & regWriteDec & (writeReg != '0); // nop and $0 writes drop here
        exeD.writeReg = writeReg;
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            exeStage_o.valid    <= 1'b0;
            exeStage_o.regWrite <= 1'b0;
        end else begin
            exeStage_o <= exeD;
        end
    end

endmodule

// ==== hdl/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit (
    input  logic               clk,
    input  logic               rstN_i,
    input  corePkg::decToExe_t exeStage_i,
    output corePkg::word_t     exeResult_o,
    output logic               exeRegWrite_o,
    output corePkg::regAddr_t  exeWriteReg_o,
    output corePkg::exeToWb_t  wbStage_o
);

    corePkg::word_t    opA;
    corePkg::word_t    opB;
    corePkg::word_t    result;
    corePkg::exeToWb_t wbD;

    assign opA = exeStage_i.operandA;
    assign opB = exeStage_i.operandB;

    always_comb begin
        case (exeStage_i.aluOp)
            corePkg::AluAdd: result = opA + opB;
            corePkg::AluSub: result = opA - opB;
            corePkg::AluAnd: result = opA & opB;
            corePkg::AluOr:  result = opA | opB;
            corePkg::AluXor: result = opA ^ opB;
            corePkg::AluSlt: result = {31'd0, $signed(opA) < $signed(opB)};
            corePkg::AluSll: result = opB << exeStage_i.shamt;
            corePkg::AluLui: result = {opB[15:0], 16'h0000};
            default:         result = '0;
        endcase
    end

    // back to decode for the distance-1 bypass
    assign exeResult_o   = result;
    assign exeRegWrite_o = exeStage_i.valid & exeStage_i.regWrite;
    assign exeWriteReg_o = exeStage_i.writeReg;

    always_comb begin
        wbD.valid    = exeStage_i.valid;
        wbD.pc       = exeStage_i.pc;
        wbD.regWrite = exeRegWrite_o;
        wbD.writeReg = exeStage_i.writeReg;
        wbD.result   = result;
    end

    // writeback register, feeds the file and the debug port
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            wbStage_o.valid    <= 1'b0;
            wbStage_o.regWrite <= 1'b0;
        end else begin
            wbStage_o <= wbD;
        end
    end

endmodule

// ==== hdl/mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore #(
    parameter corePkg::word_t ResetPc = corePkg::DefaultResetPc
) (
    input  logic              clk,
    input  logic              rstN_i,
    input  corePkg::word_t    instData_i,
    output corePkg::word_t    instAddr_o,
    output logic              instEn_o,
    output corePkg::word_t    debugWbPc_o,
    output logic [3:0]        debugWbRfWen_o,   // byte enables, all or none here
    output corePkg::regAddr_t debugWbRfWnum_o,
    output corePkg::word_t    debugWbRfWdata_o
);

    logic               fetchValid;
    corePkg::word_t     fetchPc;
    corePkg::word_t     fetchInstr;
    logic               redirect;
    corePkg::word_t     redirectPc;
    corePkg::regAddr_t  rfAddrA;
    corePkg::regAddr_t  rfAddrB;
    corePkg::word_t     rfDataA;
    corePkg::word_t     rfDataB;
    corePkg::decToExe_t exeStage;
    corePkg::word_t     exeResult;
    logic               exeRegWrite;
    corePkg::regAddr_t  exeWriteReg;
    corePkg::exeToWb_t  wbStage;
    logic               wbWrEn;

    assign wbWrEn = wbStage.valid & wbStage.regWrite;

    fetchUnit #(.ResetPc(ResetPc)) fetchUnit_inst (
        .clk(clk), .rstN_i(rstN_i),
        .redirect_i(redirect), .redirectPc_i(redirectPc), .instData_i(instData_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o),
        .fetchValid_o(fetchValid), .fetchPc_o(fetchPc), .fetchInstr_o(fetchInstr)
    );

    regFile regFile_inst (
        .clk(clk), .rstN_i(rstN_i),
        .rdAddrA_i(rfAddrA), .rdAddrB_i(rfAddrB),
        .wrEn_i(wbWrEn), .wrAddr_i(wbStage.writeReg), .wrData_i(wbStage.result),
        .rdDataA_o(rfDataA), .rdDataB_o(rfDataB)
    );

    decodeUnit decodeUnit_inst (
        .clk(clk), .rstN_i(rstN_i),
        .fetchValid_i(fetchValid), .fetchPc_i(fetchPc), .fetchInstr_i(fetchInstr),
        .exeResult_i(exeResult), .exeRegWrite_i(exeRegWrite), .exeWriteReg_i(exeWriteReg),
        .redirect_o(redirect), .redirectPc_o(redirectPc), .exeStage_o(exeStage),
        .rfAddrA_o(rfAddrA), .rfAddrB_o(rfAddrB), .rfDataA_i(rfDataA), .rfDataB_i(rfDataB)
    );

    aluUnit aluUnit_inst (
        .clk(clk), .rstN_i(rstN_i),
        .exeStage_i(exeStage),
        .exeResult_o(exeResult), .exeRegWrite_o(exeRegWrite), .exeWriteReg_o(exeWriteReg),
        .wbStage_o(wbStage)
    );

    // debug port mirrors the file write
    assign debugWbPc_o      = wbStage.pc;
    assign debugWbRfWen_o   = {4{wbWrEn}};
    assign debugWbRfWnum_o  = wbStage.writeReg;
    assign debugWbRfWdata_o = wbStage.result;

endmodule

// ==== bench/mipsCore_properties.sv ====
`timescale 1ns/1ns

module mipsCoreProperties (
    input logic              clk,
    input logic              rstN_i,
    input corePkg::word_t    instAddr_i,
    input logic              instEn_i,
    input logic [3:0]        debugWbRfWen_i,
    input corePkg::regAddr_t debugWbRfWnum_i
);

    // nothing retires while reset is held
    resetQuiet: assert property (@(posedge clk) !rstN_i |-> debugWbRfWen_i == 4'h0)
        else $error("register write seen during reset");

    // first request out of reset is the boot vector
    firstFetch: assert property (@(posedge clk)
        $rose(rstN_i) |-> instEn_i && instAddr_i == corePkg::DefaultResetPc)
        else $error("first fetch address is %h", instAddr_i);

    noZeroWrite: assert property (@(posedge clk) debugWbRfWen_i != 4'h0 |-> debugWbRfWnum_i != '0)
        else $error("write to register 0 reached the debug port");

    wordAligned: assert property (@(posedge clk) instEn_i |-> instAddr_i[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", instAddr_i);

endmodule

// ==== bench/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int          ProgWords = 64;
localparam int          LoopIdx   = ProgWords - 2;    // BEQ self-loop, then its nop
localparam logic [31:0] LcgSeed   = 32'h0d093a6b;

logic [31:0]       lcgState;
corePkg::word_t    imem [ProgWords];
corePkg::word_t    expPc [$];
corePkg::regAddr_t expNum [$];
corePkg::word_t    expData [$];

function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

// registers drawn from $0..$7 so dependencies come often
function automatic corePkg::word_t randomInstr(input bit allowBranch);
    logic [31:0]       r;
    logic [31:0]       k;
    corePkg::regAddr_t rs;
    corePkg::regAddr_t rt;
    corePkg::regAddr_t rd;
    logic [15:0]       off;
    int                sel;
    r   = nextRand();
    k   = nextRand();
    rs  = {2'b00, k[18:16]};
    rt  = {2'b00, k[21:19]};
    rd  = {2'b00, k[24:22]};
    off = {14'd0, r[1:0]};
    if (off == 16'd0) begin
        off = 16'd3;   // forward by 1 to 3 words
    end
    sel = int'(r[31:16]) % (allowBranch ? 12 : 10);
    case (sel)
        0:       return {corePkg::OpSpecial, rs, rt, rd, 5'd0, corePkg::FunctAddu};
        1:       return {corePkg::OpSpecial, rs, rt, rd, 5'd0, corePkg::FunctSubu};
        2:       return {corePkg::OpSpecial, rs, rt, rd, 5'd0, corePkg::FunctAnd};
        3:       return {corePkg::OpSpecial, rs, rt, rd, 5'd0, corePkg::FunctOr};
        4:       return {corePkg::OpSpecial, rs, rt, rd, 5'd0, corePkg::FunctXor};
        5:       return {corePkg::OpSpecial, rs, rt, rd, 5'd0, corePkg::FunctSlt};
        6:       return {corePkg::OpSpecial, 5'd0, rt, rd, k[4:0], corePkg::FunctSll};
        7:       return {corePkg::OpAddiu, rs, rt, k[15:0]};
        8:       return {corePkg::OpOri, rs, rt, k[15:0]};
        9:       return {corePkg::OpLui, 5'd0, rt, k[15:0]};
        10:      return {corePkg::OpBeq, rs, rt, off};
        11:      return {corePkg::OpBne, rs, rt, off};
        default: return '0;
    endcase
endfunction

function automatic void buildProgram();
    bit lastBranch;
    lastBranch = 1'b0;
    lcgState   = LcgSeed;
    for (int i = 0; i < LoopIdx; i++) begin
        // no branch in a delay slot, targets stay at or before the loop
        imem[i]    = randomInstr(!lastBranch && i <= LoopIdx - 4);
        lastBranch = imem[i][31:26] == corePkg::OpBeq || imem[i][31:26] == corePkg::OpBne;
    end
    imem[LoopIdx]     = {corePkg::OpBeq, 5'd0, 5'd0, 16'hFFFF};
    imem[LoopIdx + 1] = '0;
endfunction

// in-order ISA execution with one delay slot, queues every nonzero-register write
function automatic void runModel();
    corePkg::word_t    modelRegs [32];
    corePkg::word_t    instr;
    corePkg::word_t    a;
    corePkg::word_t    b;
    corePkg::word_t    res;
    corePkg::regAddr_t dest;
    logic              wr;
    int                pc;
    int                npc;
    int                nnpc;
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    pc  = 0;
    npc = 1;
    while (pc != LoopIdx) begin
        instr = imem[pc];
        a     = modelRegs[instr[25:21]];
        b     = modelRegs[instr[20:16]];
        nnpc  = npc + 1;
        wr    = 1'b1;
        res   = '0;
        dest  = instr[20:16];
        case (instr[31:26])
            corePkg::OpSpecial: begin
                dest = instr[15:11];
                case (instr[5:0])
                    corePkg::FunctAddu: res = a + b;
                    corePkg::FunctSubu: res = a - b;
                    corePkg::FunctAnd:  res = a & b;
                    corePkg::FunctOr:   res = a | b;
                    corePkg::FunctXor:  res = a ^ b;
                    corePkg::FunctSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    corePkg::FunctSll:  res = b << instr[10:6];
                    default:            wr = 1'b0;
                endcase
            end
            corePkg::OpAddiu: res = a + {{16{instr[15]}}, instr[15:0]};
            corePkg::OpOri:   res = a | {16'h0000, instr[15:0]};
            corePkg::OpLui:   res = {instr[15:0], 16'h0000};
            corePkg::OpBeq: begin
                wr = 1'b0;
                if (a == b) begin
                    nnpc = pc + 1 + int'($signed(instr[15:0]));
                end
            end
            corePkg::OpBne: begin
                wr = 1'b0;
                if (a != b) begin
                    nnpc = pc + 1 + int'($signed(instr[15:0]));
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != '0) begin
            modelRegs[dest] = res;
            expPc.push_back(corePkg::DefaultResetPc + (corePkg::word_t'(pc) << 2));
            expNum.push_back(dest);
            expData.push_back(res);
        end
        pc  = npc;
        npc = nnpc;
    end
endfunction

`endif

// ==== bench/mipsCoreTb.sv ====
`timescale 1ns/1ns

module mipsCoreTb;

    localparam int ClkPeriod = 40;

    logic              clk;
    logic              rstN = 1'b1;
    corePkg::word_t    instData;
    corePkg::word_t    instAddr;
    logic              instEn;
    corePkg::word_t    debugWbPc;
    logic [3:0]        debugWbRfWen;
    corePkg::regAddr_t debugWbRfWnum;
    corePkg::word_t    debugWbRfWdata;
    int                writeCount = 0;

    `include "isaModel.svh"

    localparam int WatchdogNs = (ProgWords + 20) * 4 * ClkPeriod;

    mipsCore mipsCore_inst (
        .clk(clk), .rstN_i(rstN), .instData_i(instData),
        .instAddr_o(instAddr), .instEn_o(instEn),
        .debugWbPc_o(debugWbPc), .debugWbRfWen_o(debugWbRfWen),
        .debugWbRfWnum_o(debugWbRfWnum), .debugWbRfWdata_o(debugWbRfWdata)
    );

    bind mipsCore mipsCoreProperties mipsCoreProperties_inst (
        .clk(clk), .rstN_i(rstN_i), .instAddr_i(instAddr_o), .instEn_i(instEn_o),
        .debugWbRfWen_i(debugWbRfWen_o), .debugWbRfWnum_i(debugWbRfWnum_o)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [5:0] memIndex(input corePkg::word_t addr);
        corePkg::word_t offset;
        offset = addr - corePkg::DefaultResetPc;
        return offset[7:2];   // 64 words, wraps past the end
    endfunction

    // synchronous instruction ROM, data one edge after the address
    always @(posedge clk) begin
        if (instEn) begin
            instData <= imem[memIndex(instAddr)];
        end
    end

    task automatic checkWord(input string testName, input corePkg::word_t expected,
                             input corePkg::word_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", testName, expected, actual);
            $display("Simulation failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkRegAddr(input string testName, input corePkg::regAddr_t expected,
                                input corePkg::regAddr_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0d actual %0d", testName, expected, actual);
            $display("Simulation failed");
            $fatal(1, "register number mismatch");
        end
    endtask

    always @(posedge clk) begin : compareWb
        corePkg::word_t    pcExp;
        corePkg::regAddr_t numExp;
        corePkg::word_t    dataExp;
        if (debugWbRfWen != 4'h0) begin
            if (expPc.size() == 0) begin
                $display("Unexpected register write to $%0d from pc %h after the last expected write",
                         debugWbRfWnum, debugWbPc);
                $display("Simulation failed");
                $fatal(1, "extra writeback");
            end else begin
                pcExp   = expPc.pop_front();
                numExp  = expNum.pop_front();
                dataExp = expData.pop_front();
                checkWord($sformatf("writeback %0d pc", writeCount), pcExp, debugWbPc);
                checkRegAddr($sformatf("writeback %0d wnum", writeCount), numExp, debugWbRfWnum);
                checkWord($sformatf("writeback %0d wdata", writeCount), dataExp, debugWbRfWdata);
                writeCount++;
            end
        end
    end

    initial begin
        instData = '0;
        rstN <= 1'b0;
        buildProgram();
        runModel();
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        while (expPc.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);   // catch stray writes past the end
        $display("%0d writebacks checked", writeCount);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout after %0d ns with %0d writebacks still missing", WatchdogNs, expPc.size());
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== filelist.f ====
+incdir+bench
hdl/corePkg.sv
hdl/fetchUnit.sv
hdl/regFile.sv
hdl/decodeUnit.sv
hdl/aluUnit.sv
hdl/mipsCore.sv
bench/mipsCore_properties.sv
bench/mipsCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mipsCoreTb -f filelist.f -o mipsCoreSim

output=$(./obj_dir/mipsCoreSim) || true
echo "$output"

if grep -q "Simulation passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
